//--- src/atg_params.svh
`ifndef ATG_PARAMS_SVH
`define ATG_PARAMS_SVH

// bus and register widths
`define ATG_DATA_W        32
`define ATG_ADDR_W        8
`define ATG_SLV_ERR_W     16
`define ATG_SLVCTL_BITS   20
`define ATG_MSTCTL_BITS   16

// register indices, paddr / 4
`define ATG_IDX_CTRL      3'd0
`define ATG_IDX_SLVCTL    3'd1
`define ATG_IDX_ERRSTS    3'd2
`define ATG_IDX_ERREN     3'd3
`define ATG_IDX_MSTCTL    3'd4
`define ATG_IDX_CONFIG    3'd5
`define ATG_IDX_NONE      3'd7
`define ATG_NUM_REGS      6

// CTRL bit positions
`define ATG_CTRL_EN_BIT   20
`define ATG_CTRL_LOOP_BIT 19
// error signalling enable in SLVCTL and MSTCTL
`define ATG_ERRSIG_BIT    15

// reset values and revision
`define ATG_REV           8'h27
`define ATG_ERREN_RESET   32'h8000_0000

// build configuration
`define ATG_M_DATA_W        64
`define ATG_S_DATA_W        32
`define ATG_MODE_BASIC      0
`define ATG_MODE_STATIC     0
`define ATG_MODE_SLVONLY    0
`define ATG_MODE_SYSINIT    0
`define ATG_MODE_STREAMING  0

`endif

//--- src/atg_pkg.sv
`include "atg_params.svh"

package atg_pkg;

  // register selected by the captured address
  typedef enum logic [2:0] {
    REG_CTRL   = `ATG_IDX_CTRL,
    REG_SLVCTL = `ATG_IDX_SLVCTL,
    REG_ERRSTS = `ATG_IDX_ERRSTS,
    REG_ERREN  = `ATG_IDX_ERREN,
    REG_MSTCTL = `ATG_IDX_MSTCTL,
    REG_CONFIG = `ATG_IDX_CONFIG,
    REG_NONE   = `ATG_IDX_NONE
  } reg_addr_e;

  // captured APB request, valid during the access cycle
  typedef struct packed {
    logic                   valid;
    logic                   write;
    reg_addr_e              addr;
    logic [`ATG_DATA_W-1:0] wdata;
  } apb_req_t;

  // master side error events
  // field order matches ERRSTS bits 20 down to 16
  typedef struct packed {
    logic mr_unexp;
    logic b_resp_unexp;
    logic b_resp_bad;
    logic mr_resp_bad;
    logic mr_bad_last;
  } mst_err_t;

  // run control and stored control register bits
  typedef struct packed {
    logic                        enable;
    logic                        loop_en;
    logic [`ATG_SLVCTL_BITS-1:0] slvctl;
    logic [`ATG_MSTCTL_BITS-1:0] mstctl;
  } ctl_state_t;

endpackage

//--- src/atg_apb_decode.sv
`timescale 1ns/1ns
`include "atg_params.svh"

module atg_apb_decode (
  input  logic                   Clk,
  input  logic                   rst_l,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`ATG_ADDR_W-1:0] paddr,
  input  logic [`ATG_DATA_W-1:0] pwdata,
  output atg_pkg::apb_req_t      req
);

  import atg_pkg::*;

  logic                   valid_q;
  logic                   write_q;
  reg_addr_e              addr_q;
  logic [`ATG_DATA_W-1:0] wdata_q;
  logic                   setup;

  // word index, anything unaligned or out of range is unmapped
  function automatic reg_addr_e map_addr(input logic [`ATG_ADDR_W-1:0] a);
    logic [`ATG_ADDR_W-3:0] idx;
    idx = a[`ATG_ADDR_W-1:2];
    if (a[1:0] != 2'b00 || idx >= `ATG_NUM_REGS) begin
      return REG_NONE;
    end
    return reg_addr_e'(idx[2:0]);
  endfunction

  assign setup = psel && !penable;

  // valid lasts exactly one cycle, the access phase
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= setup;
    end
  end

  always_ff @(posedge Clk) begin
    if (setup) begin
      write_q <= pwrite;
      addr_q  <= map_addr(paddr);
      wdata_q <= pwdata;
    end
  end

  assign req = '{valid: valid_q, write: write_q, addr: addr_q, wdata: wdata_q};

  // an access phase must follow a captured setup phase
  a_access_after_setup: assert property (@(posedge Clk) disable iff (!rst_l)
    psel && penable |-> req.valid);

endmodule

//--- src/atg_ctl_regs.sv
`timescale 1ns/1ns
`include "atg_params.svh"

module atg_ctl_regs (
  input  logic                Clk,
  input  logic                rst_l,
  input  atg_pkg::apb_req_t   req,
  input  logic                global_start,
  input  logic                global_stop,
  input  logic                mr_done,
  input  logic                mw_done,
  output atg_pkg::ctl_state_t ctl,
  output logic                run_start
);

  import atg_pkg::*;

  logic start_q;
  logic stop_q;
  logic start_pulse;
  logic stop_pulse;
  logic run_done;
  logic wr_ctrl;
  logic wr_slvctl;
  logic wr_mstctl;

  // previous levels of the global inputs
  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      start_q <= 1'b0;
      stop_q  <= 1'b0;
    end else begin
      start_q <= global_start;
      stop_q  <= global_stop;
    end
  end

  assign start_pulse = global_start && !start_q;
  assign stop_pulse  = global_stop && !stop_q;
  assign run_done    = mr_done && mw_done;

  assign wr_ctrl   = req.valid && req.write && (req.addr == REG_CTRL);
  assign wr_slvctl = req.valid && req.write && (req.addr == REG_SLVCTL);
  assign wr_mstctl = req.valid && req.write && (req.addr == REG_MSTCTL);

  // set has priority over the done clear
  assign run_start = (wr_ctrl && req.wdata[`ATG_CTRL_EN_BIT]) || start_pulse;

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      ctl <= '0;
    end else begin
      if (run_start) begin
        ctl.enable <= 1'b1;
      end else if (run_done) begin
        ctl.enable <= 1'b0;
      end
      // a CTRL write beats the stop edge
      if (wr_ctrl) begin
        ctl.loop_en <= req.wdata[`ATG_CTRL_LOOP_BIT];
      end else if (stop_pulse) begin
        ctl.loop_en <= 1'b0;
      end
      if (wr_slvctl) begin
        ctl.slvctl <= req.wdata[`ATG_SLVCTL_BITS-1:0];
      end
      if (wr_mstctl) begin
        ctl.mstctl <= req.wdata[`ATG_MSTCTL_BITS-1:0];
      end
    end
  end

  a_done_clears_enable: assert property (@(posedge Clk) disable iff (!rst_l)
    run_done && !run_start |=> !ctl.enable);

endmodule

//--- src/atg_err_regs.sv
`timescale 1ns/1ns
`include "atg_params.svh"

module atg_err_regs (
  input  logic                     Clk,
  input  logic                     rst_l,
  input  atg_pkg::apb_req_t        req,
  input  atg_pkg::ctl_state_t      ctl,
  input  logic                     run_start,
  input  logic                     mr_done,
  input  logic                     mw_done,
  input  logic [`ATG_SLV_ERR_W-1:0] slv_err,
  input  atg_pkg::mst_err_t        mst_err,
  output logic [`ATG_DATA_W-1:0]   errsts,
  output logic [`ATG_DATA_W-1:0]   erren,
  output logic                     err_out,
  output logic                     irq_out
);

  import atg_pkg::*;

  logic                   wr_errsts;
  logic                   wr_erren;
  logic [`ATG_DATA_W-1:0] events;
  logic [`ATG_DATA_W-1:0] cleared;
  logic [`ATG_DATA_W-1:0] errsts_nxt;
  logic                   err_slv;
  logic                   err_mst;

  assign wr_errsts = req.valid && req.write && (req.addr == REG_ERRSTS);
  assign wr_erren  = req.valid && req.write && (req.addr == REG_ERREN);

  // done in bit 31, master events 20:16, slave events 15:0
  assign events = {mr_done && mw_done, 10'b0, mst_err, slv_err};

  // write one to clear, new events win over the clear
  assign cleared    = wr_errsts ? (errsts & ~req.wdata) : errsts;
  assign errsts_nxt = run_start ? '0 : (cleared | (events & erren));

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      errsts <= '0;
      erren  <= `ATG_ERREN_RESET;
    end else begin
      errsts <= errsts_nxt;
      if (wr_erren) begin
        erren <= req.wdata;
      end
    end
  end

  // summary looks at the registered status
  assign err_slv = ctl.slvctl[`ATG_ERRSIG_BIT] && (errsts[`ATG_SLV_ERR_W-1:0] != '0);
  assign err_mst = ctl.mstctl[`ATG_ERRSIG_BIT] &&
                   (errsts[`ATG_DATA_W-2:`ATG_SLV_ERR_W] != '0);

  always_ff @(posedge Clk) begin
    if (!rst_l) begin
      err_out <= 1'b0;
    end else begin
      err_out <= err_slv || err_mst;
    end
  end

  assign irq_out = errsts[`ATG_DATA_W-1];

  // a new run always starts from a clean status
  a_run_start_clears: assert property (@(posedge Clk) disable iff (!rst_l)
    run_start |=> (errsts == '0));

endmodule

//--- src/atg_rd_resp.sv
`timescale 1ns/1ns
`include "atg_params.svh"

module atg_rd_resp (
  input  atg_pkg::apb_req_t      req,
  input  atg_pkg::ctl_state_t    ctl,
  input  logic [`ATG_DATA_W-1:0] errsts,
  input  logic [`ATG_DATA_W-1:0] erren,
  output logic                   pready,
  output logic [`ATG_DATA_W-1:0] prdata,
  output logic                   pslverr
);

  import atg_pkg::*;

  logic [`ATG_DATA_W-1:0] ctrl_word;
  logic [`ATG_DATA_W-1:0] config_word;
  logic                   mode_full;

  // AXI data width to CONFIG code
  function automatic logic [2:0] width_code(input int w);
    case (w)
      64:      return 3'd1;
      128:     return 3'd2;
      256:     return 3'd3;
      512:     return 3'd4;
      default: return 3'd0;
    endcase
  endfunction

  assign mode_full = (`ATG_MODE_BASIC == 0) && (`ATG_MODE_STATIC == 0) &&
                     (`ATG_MODE_SLVONLY == 0) && (`ATG_MODE_SYSINIT == 0) &&
                     (`ATG_MODE_STREAMING == 0);

  always_comb begin
    ctrl_word = '0;
    ctrl_word[31:24] = `ATG_REV;
    ctrl_word[`ATG_CTRL_EN_BIT] = ctl.enable;
    ctrl_word[`ATG_CTRL_LOOP_BIT] = ctl.loop_en;

    config_word = '0;
    config_word[30:28] = width_code(`ATG_M_DATA_W);
    config_word[27:25] = width_code(`ATG_S_DATA_W);
    config_word[24] = mode_full;
    config_word[23] = (`ATG_MODE_BASIC != 0);
    config_word[22] = (`ATG_MODE_STATIC != 0);
    config_word[21] = (`ATG_MODE_SLVONLY != 0);
    config_word[20] = (`ATG_MODE_SYSINIT != 0);
    config_word[19] = (`ATG_MODE_STREAMING != 0);
  end

  // no wait states, response in the access cycle
  assign pready  = req.valid;
  assign pslverr = req.valid && (req.addr == REG_NONE);

  always_comb begin
    prdata = '0;
    if (req.valid) begin
      case (req.addr)
        REG_CTRL:   prdata = ctrl_word;
        REG_SLVCTL: prdata = `ATG_DATA_W'(ctl.slvctl);
        REG_ERRSTS: prdata = errsts;
        REG_ERREN:  prdata = erren;
        REG_MSTCTL: prdata = `ATG_DATA_W'(ctl.mstctl);
        REG_CONFIG: prdata = config_word;
        default:    prdata = '0;
      endcase
    end
  end

endmodule

//--- src/atg_regs_top.sv
`timescale 1ns/1ns
`include "atg_params.svh"

module atg_regs_top (
  input  logic                      Clk,
  input  logic                      rst_l,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`ATG_ADDR_W-1:0]    paddr,
  input  logic [`ATG_DATA_W-1:0]    pwdata,
  output logic                      pready,
  output logic [`ATG_DATA_W-1:0]    prdata,
  output logic                      pslverr,
  input  logic                      global_start,
  input  logic                      global_stop,
  input  logic                      mr_done,
  input  logic                      mw_done,
  input  logic [`ATG_SLV_ERR_W-1:0] slv_err,
  input  atg_pkg::mst_err_t         mst_err,
  output logic                      run_enable,
  output logic                      loop_en,
  output logic                      sgl_slv_rd,
  output logic                      sgl_slv_wr,
  output logic                      disallow_excl,
  output logic                      wrs_block_rds,
  output logic                      err_out,
  output logic                      irq_out
);

  import atg_pkg::*;

  apb_req_t               req;
  ctl_state_t             ctl;
  logic                   run_start;
  logic [`ATG_DATA_W-1:0] errsts;
  logic [`ATG_DATA_W-1:0] erren;

  atg_apb_decode atg_apb_decode_i (
    .Clk     (Clk),
    .rst_l   (rst_l),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .req     (req)
  );

  atg_ctl_regs atg_ctl_regs_i (
    .Clk          (Clk),
    .rst_l        (rst_l),
    .req          (req),
    .global_start (global_start),
    .global_stop  (global_stop),
    .mr_done      (mr_done),
    .mw_done      (mw_done),
    .ctl          (ctl),
    .run_start    (run_start)
  );

  atg_err_regs atg_err_regs_i (
    .Clk       (Clk),
    .rst_l     (rst_l),
    .req       (req),
    .ctl       (ctl),
    .run_start (run_start),
    .mr_done   (mr_done),
    .mw_done   (mw_done),
    .slv_err   (slv_err),
    .mst_err   (mst_err),
    .errsts    (errsts),
    .erren     (erren),
    .err_out   (err_out),
    .irq_out   (irq_out)
  );

  atg_rd_resp atg_rd_resp_i (
    .req     (req),
    .ctl     (ctl),
    .errsts  (errsts),
    .erren   (erren),
    .pready  (pready),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  // control outputs straight from the stored bits
  assign run_enable    = ctl.enable;
  assign loop_en       = ctl.loop_en;
  assign sgl_slv_rd    = ctl.slvctl[16];
  assign sgl_slv_wr    = ctl.slvctl[17];
  assign disallow_excl = ctl.slvctl[18];
  assign wrs_block_rds = ctl.slvctl[19];

endmodule

//--- bench/tb_atg_regs.sv
`timescale 1ns/1ns
`include "atg_params.svh"

module tb_atg_regs;

  import atg_pkg::*;

  // register byte addresses at four times the index
  localparam logic [7:0] addr_ctrl   = 8'h00;
  localparam logic [7:0] addr_slvctl = 8'h04;
  localparam logic [7:0] addr_errsts = 8'h08;
  localparam logic [7:0] addr_erren  = 8'h0c;
  localparam logic [7:0] addr_mstctl = 8'h10;
  localparam logic [7:0] addr_config = 8'h14;
  localparam int timeout_cycles = 50;
  localparam int sel_run_enable = 0;
  localparam int sel_loop_en    = 1;
  localparam int sel_err_out    = 2;
  localparam int sel_irq_out    = 3;

  logic        Clk;
  logic        rst_l;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;
  logic        global_start;
  logic        global_stop;
  logic        mr_done;
  logic        mw_done;
  logic [15:0] slv_err;
  mst_err_t    mst_err;
  logic        run_enable;
  logic        loop_en;
  logic        sgl_slv_rd;
  logic        sgl_slv_wr;
  logic        disallow_excl;
  logic        wrs_block_rds;
  logic        err_out;
  logic        irq_out;

  int          errors;
  int          checks;
  int          tests;
  int          test_errors;
  string       test_name;
  logic [31:0] lfsr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        rerr;
  logic [31:0] sts;
  mst_err_t    mst_pat;

  atg_regs_top atg_regs_top_i (
    .Clk           (Clk),
    .rst_l         (rst_l),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .pready        (pready),
    .prdata        (prdata),
    .pslverr       (pslverr),
    .global_start  (global_start),
    .global_stop   (global_stop),
    .mr_done       (mr_done),
    .mw_done       (mw_done),
    .slv_err       (slv_err),
    .mst_err       (mst_err),
    .run_enable    (run_enable),
    .loop_en       (loop_en),
    .sgl_slv_rd    (sgl_slv_rd),
    .sgl_slv_wr    (sgl_slv_wr),
    .disallow_excl (disallow_excl),
    .wrs_block_rds (wrs_block_rds),
    .err_out       (err_out),
    .irq_out       (irq_out)
  );

  always #50 Clk = ~Clk;

  // pready belongs to the access phase only
  a_pready_in_access: assert property (@(posedge Clk) disable iff (!rst_l)
    pready |-> psel && penable)
    else begin
      errors++;
      $display("pready was high outside an APB access cycle");
    end

  // interrupt matches bit 31 of the expected status at each status read
  a_irq_matches_read: assert property (@(posedge Clk) disable iff (!rst_l)
    psel && penable && !pwrite && (paddr == addr_errsts) |-> irq_out == sts[31])
    else begin
      errors++;
      $display("irq_out differs from bit 31 of the expected ERRSTS value");
    end

  // right shifting form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  // width code is log2 of width in 32 bit units
  function automatic logic [31:0] expected_config();
    logic [31:0] w;
    logic [4:0]  modes;
    modes = {(`ATG_MODE_BASIC != 0), (`ATG_MODE_STATIC != 0), (`ATG_MODE_SLVONLY != 0),
             (`ATG_MODE_SYSINIT != 0), (`ATG_MODE_STREAMING != 0)};
    w = '0;
    w[30:28] = 3'($clog2(`ATG_M_DATA_W / 32));
    w[27:25] = 3'($clog2(`ATG_S_DATA_W / 32));
    w[24] = (modes == 5'b0);
    w[23:19] = modes;
    return w;
  endfunction

  function automatic logic pick_out(input int sel);
    case (sel)
      sel_run_enable: return run_enable;
      sel_loop_en:    return loop_en;
      sel_err_out:    return err_out;
      default:        return irq_out;
    endcase
  endfunction

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    a_value: assert (actual === expected)
      else begin
        errors++;
        $display("Error %s expected %h actual %h", name, expected, actual);
      end
  endtask

  task automatic wait_for(input string what, input int sel, input logic level);
    int cycles;
    cycles = 0;
    @(negedge Clk);
    while (pick_out(sel) !== level) begin
      if (cycles == timeout_cycles) begin
        abort_run(what);
      end
      cycles++;
      @(negedge Clk);
    end
  endtask

  // setup cycle then access cycle with data sampled mid cycle
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rd,
                              output logic err);
    int cycles;
    @(posedge Clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= data;
    @(posedge Clk);
    penable <= 1'b1;
    cycles = 0;
    @(negedge Clk);
    while (!pready) begin
      if (cycles == timeout_cycles) begin
        abort_run("pready");
      end
      cycles++;
      @(negedge Clk);
    end
    rd = prdata;
    err = pslverr;
    @(posedge Clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b1, addr, data, rd, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rd, output logic err);
    apb_transfer(1'b0, addr, 32'h0, rd, err);
  endtask

  // events last a single cycle
  task automatic pulse_events(input logic [15:0] slv, input mst_err_t mst, input logic done);
    @(posedge Clk);
    slv_err <= slv;
    mst_err <= mst;
    mr_done <= done;
    mw_done <= done;
    @(posedge Clk);
    slv_err <= '0;
    mst_err <= '0;
    mr_done <= 1'b0;
    mw_done <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_errors) begin
      $display("test %0d %s ok", tests, test_name);
    end else begin
      $display("test %0d %s failed, %0d errors", tests, test_name, errors - test_errors);
    end
  endtask

  initial begin
    Clk = 1'b0;
    rst_l = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    global_start = 1'b0;
    global_stop = 1'b0;
    mr_done = 1'b0;
    mw_done = 1'b0;
    slv_err = '0;
    mst_err = '0;
    errors = 0;
    checks = 0;
    tests = 0;
    sts = '0;
    lfsr = 32'h7c14;
    repeat (3) @(posedge Clk);
    rst_l <= 1'b1;

    start_test("reset_values");
    apb_read(addr_ctrl, rdata, rerr);
    check_value("ctrl_reset", {`ATG_REV, 24'h0}, rdata);
    apb_read(addr_erren, rdata, rerr);
    check_value("erren_reset", `ATG_ERREN_RESET, rdata);
    apb_read(addr_config, rdata, rerr);
    check_value("config_reset", expected_config(), rdata);
    @(negedge Clk);
    check_value("outputs_reset", 32'h0, {24'h0, run_enable, loop_en, sgl_slv_rd, sgl_slv_wr,
                                         disallow_excl, wrs_block_rds, err_out, irq_out});
    end_test();

    start_test("control_regs");
    repeat (3) begin
      random_word(wdata);
      apb_write(addr_slvctl, wdata);
      apb_read(addr_slvctl, rdata, rerr);
      check_value("slvctl_readback", wdata & 32'h000f_ffff, rdata);
      @(negedge Clk);
      check_value("slvctl_outputs", {28'h0, wdata[19:16]},
                  {28'h0, wrs_block_rds, disallow_excl, sgl_slv_wr, sgl_slv_rd});
      random_word(wdata);
      apb_write(addr_mstctl, wdata);
      apb_read(addr_mstctl, rdata, rerr);
      check_value("mstctl_readback", wdata & 32'h0000_ffff, rdata);
    end
    apb_write(addr_slvctl, 32'h0);
    apb_write(addr_mstctl, 32'h0);
    end_test();

    start_test("run_control");
    apb_write(addr_ctrl, 32'h0010_0000);
    wait_for("run_enable set by CTRL write", sel_run_enable, 1'b1);
    pulse_events(16'h0, '0, 1'b1);
    wait_for("run_enable cleared by done", sel_run_enable, 1'b0);
    @(posedge Clk);
    global_start <= 1'b1;
    wait_for("run_enable set by global_start", sel_run_enable, 1'b1);
    @(posedge Clk);
    global_start <= 1'b0;
    apb_write(addr_ctrl, 32'h0008_0000);
    wait_for("loop_en set by CTRL write", sel_loop_en, 1'b1);
    apb_read(addr_ctrl, rdata, rerr);
    check_value("ctrl_running", {`ATG_REV, 24'h18_0000}, rdata);
    @(posedge Clk);
    global_stop <= 1'b1;
    wait_for("loop_en cleared by global_stop", sel_loop_en, 1'b0);
    @(posedge Clk);
    global_stop <= 1'b0;
    end_test();

    start_test("error_status");
    apb_write(addr_erren, 32'hffff_ffff);
    random_word(wdata);
    // expect ERRSTS bits 20 and 18
    mst_pat = '{mr_unexp: 1'b1, b_resp_unexp: 1'b0, b_resp_bad: 1'b1,
                mr_resp_bad: 1'b0, mr_bad_last: 1'b0};
    pulse_events(wdata[15:0], mst_pat, 1'b0);
    sts = {16'h0014, wdata[15:0]};
    apb_read(addr_errsts, rdata, rerr);
    check_value("errsts_events", sts, rdata);
    apb_write(addr_errsts, 32'h0010_00ff);
    sts = sts & ~32'h0010_00ff;
    apb_read(addr_errsts, rdata, rerr);
    check_value("errsts_clear", sts, rdata);
    pulse_events(16'h0, '0, 1'b1);
    wait_for("irq_out after run done", sel_irq_out, 1'b1);
    sts = sts | 32'h8000_0000;
    apb_read(addr_errsts, rdata, rerr);
    check_value("errsts_done", sts, rdata);
    apb_write(addr_ctrl, 32'h0010_0000);
    sts = 32'h0;
    apb_read(addr_errsts, rdata, rerr);
    check_value("errsts_run_start", sts, rdata);
    end_test();

    start_test("error_summary");
    apb_write(addr_slvctl, 32'h0000_8000);
    pulse_events(16'h0008, '0, 1'b0);
    wait_for("err_out on slave event", sel_err_out, 1'b1);
    apb_write(addr_errsts, 32'hffff_ffff);
    wait_for("err_out low after clear", sel_err_out, 1'b0);
    end_test();

    start_test("unmapped_and_config");
    apb_read(8'h18, rdata, rerr);
    check_value("unmapped_data", 32'h0, rdata);
    check_value("unmapped_pslverr", 32'h1, {31'h0, rerr});
    // unaligned address inside the map
    apb_read(8'h05, rdata, rerr);
    check_value("unaligned_data", 32'h0, rdata);
    check_value("unaligned_pslverr", 32'h1, {31'h0, rerr});
    random_word(wdata);
    apb_write(addr_config, wdata);
    apb_read(addr_config, rdata, rerr);
    check_value("config_after_write", expected_config(), rdata);
    check_value("config_pslverr", 32'h0, {31'h0, rerr});
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- atg_regs_top.f
+incdir+src
src/atg_pkg.sv
src/atg_apb_decode.sv
src/atg_ctl_regs.sv
src/atg_err_regs.sv
src/atg_rd_resp.sv
src/atg_regs_top.sv
bench/tb_atg_regs.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the register block testbench with Verilator
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log=sim.log

verilator --binary --assert --top-module tb_atg_regs -Mdir "$build_dir" -f atg_regs_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_atg_regs" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the fail line on any failed check or timeout
if grep -q ">>> FAIL" "$log"; then
  exit 1
fi
exit 0
